//--- build.f
cpu_pkg.sv
reg_file.sv
forward.sv
decode_stage.sv
execute_stage.sv
result_stage.sv
cpu_core.sv
tb_cpu_core.sv

//--- cpu_core.sv
module cpu_core import cpu_pkg::*; #(
	parameter int DMEM_DEPTH = 64
) (
	input  logic      clk,
	input  logic      rst_n,

	input  logic      instr_valid,
	input  word_t     instr,
	output logic      instr_ready,

	output logic      wb_valid,
	output reg_addr_t wb_addr,
	output word_t     wb_data
);

	logic      dec_valid;
	reg_addr_t dec_rd;
	wr_src_t   dec_wr_src;
	logic      dec_dm_read;
	logic      dec_dm_write;
	alu_op_t   dec_alu_op;
	logic      dec_use_imm;
	word_t     dec_imm;
	word_t     dec_ra_data;
	word_t     dec_rb_data;
	word_t     dec_rt_data;

	logic      ex_valid;
	logic      ex_reg_write;
	logic      ex_dm_read;
	logic      ex_dm_write;
	wr_src_t   ex_wr_src;
	reg_addr_t ex_rd;
	word_t     ex_imm;
	word_t     ex_rt_data;
	word_t     alu_result;

	logic      mem_reg_write;
	reg_addr_t mem_rd;
	word_t     mem_wr_data;
	logic      wb_reg_write;
	reg_addr_t wb_rd;
	word_t     wb_wr_data;

	decode_stage u_decode_stage (
		.clk           (clk),
		.rst_n         (rst_n),
		.instr_valid   (instr_valid),
		.instr         (instr),
		.instr_ready   (instr_ready),
		.ex_dm_read    (ex_dm_read),
		.ex_reg_write  (ex_reg_write),
		.ex_wr_src     (ex_wr_src),
		.ex_rd         (ex_rd),
		.ex_imm        (ex_imm),
		.alu_result    (alu_result),
		.mem_reg_write (mem_reg_write),
		.mem_rd        (mem_rd),
		.mem_wr_data   (mem_wr_data),
		.wb_reg_write  (wb_reg_write),
		.wb_rd         (wb_rd),
		.wb_wr_data    (wb_wr_data),
		.dec_valid     (dec_valid),
		.dec_rd        (dec_rd),
		.dec_wr_src    (dec_wr_src),
		.dec_dm_read   (dec_dm_read),
		.dec_dm_write  (dec_dm_write),
		.dec_alu_op    (dec_alu_op),
		.dec_use_imm   (dec_use_imm),
		.dec_imm       (dec_imm),
		.dec_ra_data   (dec_ra_data),
		.dec_rb_data   (dec_rb_data),
		.dec_rt_data   (dec_rt_data)
	);

	execute_stage u_execute_stage (
		.clk          (clk),
		.rst_n        (rst_n),
		.dec_valid    (dec_valid),
		.dec_rd       (dec_rd),
		.dec_wr_src   (dec_wr_src),
		.dec_dm_read  (dec_dm_read),
		.dec_dm_write (dec_dm_write),
		.dec_alu_op   (dec_alu_op),
		.dec_use_imm  (dec_use_imm),
		.dec_imm      (dec_imm),
		.dec_ra_data  (dec_ra_data),
		.dec_rb_data  (dec_rb_data),
		.dec_rt_data  (dec_rt_data),
		.ex_valid     (ex_valid),
		.ex_reg_write (ex_reg_write),
		.ex_dm_read   (ex_dm_read),
		.ex_dm_write  (ex_dm_write),
		.ex_wr_src    (ex_wr_src),
		.ex_rd        (ex_rd),
		.ex_imm       (ex_imm),
		.ex_rt_data   (ex_rt_data),
		.alu_result   (alu_result)
	);

	result_stage #(
		.DMEM_DEPTH (DMEM_DEPTH)
	) u_result_stage (
		.clk           (clk),
		.rst_n         (rst_n),
		.ex_valid      (ex_valid),
		.ex_rd         (ex_rd),
		.ex_wr_src     (ex_wr_src),
		.ex_dm_read    (ex_dm_read),
		.ex_dm_write   (ex_dm_write),
		.alu_result    (alu_result),
		.ex_imm        (ex_imm),
		.ex_rt_data    (ex_rt_data),
		.mem_reg_write (mem_reg_write),
		.mem_rd        (mem_rd),
		.mem_wr_data   (mem_wr_data),
		.wb_reg_write  (wb_reg_write),
		.wb_rd         (wb_rd),
		.wb_wr_data    (wb_wr_data),
		.wb_valid      (wb_valid),
		.wb_addr       (wb_addr),
		.wb_data       (wb_data)
	);

endmodule

//--- cpu_pkg.sv
package cpu_pkg;

	// data word, register number and opcode widths.
	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [3:0]  opcode_t;
	typedef logic [2:0]  alu_op_t;
	typedef logic [1:0]  wr_src_t;

	// opcodes, every value not listed is a no-op.
	localparam opcode_t OP_NOP  = 4'd0;
	localparam opcode_t OP_ADD  = 4'd1;
	localparam opcode_t OP_SUB  = 4'd2;
	localparam opcode_t OP_AND  = 4'd3;
	localparam opcode_t OP_OR   = 4'd4;
	localparam opcode_t OP_XOR  = 4'd5;
	localparam opcode_t OP_LI   = 4'd6;
	localparam opcode_t OP_ADDI = 4'd7;
	localparam opcode_t OP_LW   = 4'd8;
	localparam opcode_t OP_SW   = 4'd9;

	// instruction field positions.
	localparam int OPC_MSB = 31;
	localparam int OPC_LSB = 28;
	localparam int RT_MSB  = 25;
	localparam int RT_LSB  = 21;
	localparam int RA_MSB  = 20;
	localparam int RA_LSB  = 16;
	localparam int RB_MSB  = 15;
	localparam int RB_LSB  = 11;
	localparam int IMM_MSB = 15;
	localparam int IMM_LSB = 0;

	// alu operations.
	localparam alu_op_t ALU_ADD = 3'd0;
	localparam alu_op_t ALU_SUB = 3'd1;
	localparam alu_op_t ALU_AND = 3'd2;
	localparam alu_op_t ALU_OR  = 3'd3;
	localparam alu_op_t ALU_XOR = 3'd4;

	// source of the value written to the register file.
	localparam wr_src_t WRREG_NONE      = 2'd0;
	localparam wr_src_t WRREG_ALURESULT = 2'd1;
	localparam wr_src_t WRREG_IMMDATA   = 2'd2;
	localparam wr_src_t WRREG_MEMDATA   = 2'd3;

endpackage

//--- decode_stage.sv
module decode_stage import cpu_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,

	input  logic      instr_valid,
	input  word_t     instr,
	output logic      instr_ready,

	input  logic      ex_dm_read,
	input  logic      ex_reg_write,
	input  wr_src_t   ex_wr_src,
	input  reg_addr_t ex_rd,
	input  word_t     ex_imm,
	input  word_t     alu_result,

	input  logic      mem_reg_write,
	input  reg_addr_t mem_rd,
	input  word_t     mem_wr_data,

	input  logic      wb_reg_write,
	input  reg_addr_t wb_rd,
	input  word_t     wb_wr_data,

	output logic      dec_valid,
	output reg_addr_t dec_rd,
	output wr_src_t   dec_wr_src,
	output logic      dec_dm_read,
	output logic      dec_dm_write,
	output alu_op_t   dec_alu_op,
	output logic      dec_use_imm,
	output word_t     dec_imm,
	output word_t     dec_ra_data,
	output word_t     dec_rb_data,
	output word_t     dec_rt_data
);

	logic      dec_full;
	word_t     instr_q;
	opcode_t   opcode;
	reg_addr_t ra_addr;
	reg_addr_t rb_addr;
	reg_addr_t rt_addr;
	word_t     ra_data;
	word_t     rb_data;
	word_t     rt_data;
	logic      do_hazard;
	logic      stall;

	// an empty decode register never stalls.
	assign stall = dec_full && do_hazard;

	// the register moves on every cycle except during a stall.
	assign instr_ready = !stall;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			dec_full <= 1'b0;
		else if (instr_ready)
			dec_full <= instr_valid;
	end

	always_ff @(posedge clk) begin
		if (instr_valid && instr_ready)
			instr_q <= instr;
	end

	assign opcode  = instr_q[OPC_MSB:OPC_LSB];
	assign rt_addr = instr_q[RT_MSB:RT_LSB];
	assign ra_addr = instr_q[RA_MSB:RA_LSB];
	assign rb_addr = instr_q[RB_MSB:RB_LSB];
	assign dec_imm = word_t'(signed'(instr_q[IMM_MSB:IMM_LSB]));
	assign dec_rd  = rt_addr;

	always_comb begin
		dec_wr_src   = WRREG_NONE;
		dec_dm_read  = 1'b0;
		dec_dm_write = 1'b0;
		dec_alu_op   = ALU_ADD;
		dec_use_imm  = 1'b0;
		case (opcode)
			OP_ADD: dec_wr_src = WRREG_ALURESULT;
			OP_SUB: begin
				dec_wr_src = WRREG_ALURESULT;
				dec_alu_op = ALU_SUB;
			end
			OP_AND: begin
				dec_wr_src = WRREG_ALURESULT;
				dec_alu_op = ALU_AND;
			end
			OP_OR: begin
				dec_wr_src = WRREG_ALURESULT;
				dec_alu_op = ALU_OR;
			end
			OP_XOR: begin
				dec_wr_src = WRREG_ALURESULT;
				dec_alu_op = ALU_XOR;
			end
			OP_LI: dec_wr_src = WRREG_IMMDATA;
			OP_ADDI: begin
				dec_wr_src  = WRREG_ALURESULT;
				dec_use_imm = 1'b1;
			end
			// address is ra plus the immediate.
			OP_LW: begin
				dec_wr_src  = WRREG_MEMDATA;
				dec_dm_read = 1'b1;
				dec_use_imm = 1'b1;
			end
			OP_SW: begin
				dec_dm_write = 1'b1;
				dec_use_imm  = 1'b1;
			end
			default: dec_wr_src = WRREG_NONE;
		endcase
	end

	// a stall sends a bubble to execute.
	assign dec_valid = dec_full && !do_hazard;

	reg_file u_reg_file (
		.clk     (clk),
		.rst_n   (rst_n),
		.ra_addr (ra_addr),
		.rb_addr (rb_addr),
		.rt_addr (rt_addr),
		.ra_data (ra_data),
		.rb_data (rb_data),
		.rt_data (rt_data),
		.we      (wb_reg_write),
		.wr_addr (wb_rd),
		.wr_data (wb_wr_data)
	);

	forward u_forward (
		.reg_ra_addr   (ra_addr),
		.reg_rb_addr   (rb_addr),
		.reg_rt_addr   (rt_addr),
		.reg_ra_data   (ra_data),
		.reg_rb_data   (rb_data),
		.reg_rt_data   (rt_data),
		.ex_dm_read    (ex_dm_read),
		.ex_reg_write  (ex_reg_write),
		.ex_wr_src     (ex_wr_src),
		.ex_rd         (ex_rd),
		.ex_imm        (ex_imm),
		.alu_result    (alu_result),
		.mem_reg_write (mem_reg_write),
		.mem_rd        (mem_rd),
		.mem_wr_data   (mem_wr_data),
		.wb_reg_write  (wb_reg_write),
		.wb_rd         (wb_rd),
		.wb_wr_data    (wb_wr_data),
		.f_reg_ra_data (dec_ra_data),
		.f_reg_rb_data (dec_rb_data),
		.f_reg_rt_data (dec_rt_data),
		.do_hazard     (do_hazard)
	);

	// the bubble takes the load out of execute, so a stall lasts one cycle.
	a_one_cycle_stall: assert property (
		@(posedge clk) disable iff (!rst_n)
		stall |=> !do_hazard
	) else $error("load-use stall lasted more than one cycle");

endmodule

//--- execute_stage.sv
module execute_stage import cpu_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,

	input  logic      dec_valid,
	input  reg_addr_t dec_rd,
	input  wr_src_t   dec_wr_src,
	input  logic      dec_dm_read,
	input  logic      dec_dm_write,
	input  alu_op_t   dec_alu_op,
	input  logic      dec_use_imm,
	input  word_t     dec_imm,
	input  word_t     dec_ra_data,
	input  word_t     dec_rb_data,
	input  word_t     dec_rt_data,

	output logic      ex_valid,
	output logic      ex_reg_write,
	output logic      ex_dm_read,
	output logic      ex_dm_write,
	output wr_src_t   ex_wr_src,
	output reg_addr_t ex_rd,
	output word_t     ex_imm,
	output word_t     ex_rt_data,
	output word_t     alu_result
);

	alu_op_t ex_alu_op;
	logic    ex_use_imm;
	word_t   ex_ra_data;
	word_t   ex_rb_data;
	word_t   operand_b;

	// control is cleared for a bubble.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_valid    <= 1'b0;
			ex_wr_src   <= WRREG_NONE;
			ex_dm_read  <= 1'b0;
			ex_dm_write <= 1'b0;
		end else begin
			ex_valid    <= dec_valid;
			ex_wr_src   <= dec_valid ? dec_wr_src : WRREG_NONE;
			ex_dm_read  <= dec_valid && dec_dm_read;
			ex_dm_write <= dec_valid && dec_dm_write;
		end
	end

	always_ff @(posedge clk) begin
		ex_rd      <= dec_rd;
		ex_alu_op  <= dec_alu_op;
		ex_use_imm <= dec_use_imm;
		ex_imm     <= dec_imm;
		ex_ra_data <= dec_ra_data;
		ex_rb_data <= dec_rb_data;
		ex_rt_data <= dec_rt_data;
	end

	assign ex_reg_write = ex_valid && (ex_wr_src != WRREG_NONE);

	// also the word address for loads and stores.
	assign operand_b = ex_use_imm ? ex_imm : ex_rb_data;

	always_comb begin
		case (ex_alu_op)
			ALU_SUB: alu_result = ex_ra_data - operand_b;
			ALU_AND: alu_result = ex_ra_data & operand_b;
			ALU_OR:  alu_result = ex_ra_data | operand_b;
			ALU_XOR: alu_result = ex_ra_data ^ operand_b;
			default: alu_result = ex_ra_data + operand_b;
		endcase
	end

	a_load_store_excl: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(ex_dm_read && ex_dm_write)
	) else $error("load and store flags both set in execute");

endmodule

//--- forward.sv
module forward import cpu_pkg::*; (
	input  reg_addr_t reg_ra_addr,
	input  reg_addr_t reg_rb_addr,
	input  reg_addr_t reg_rt_addr,

	input  word_t     reg_ra_data,
	input  word_t     reg_rb_data,
	input  word_t     reg_rt_data,

	input  logic      ex_dm_read,
	input  logic      ex_reg_write,
	input  wr_src_t   ex_wr_src,
	input  reg_addr_t ex_rd,
	input  word_t     ex_imm,
	input  word_t     alu_result,

	input  logic      mem_reg_write,
	input  reg_addr_t mem_rd,
	input  word_t     mem_wr_data,

	input  logic      wb_reg_write,
	input  reg_addr_t wb_rd,
	input  word_t     wb_wr_data,

	output word_t     f_reg_ra_data,
	output word_t     f_reg_rb_data,
	output word_t     f_reg_rt_data,

	output logic      do_hazard
);

	logic  ex_fwd_ok;
	word_t ex_fwd_data;

	// a load in execute has no data yet and is never forwarded.
	assign ex_fwd_ok = ex_reg_write && !ex_dm_read &&
		(ex_wr_src == WRREG_IMMDATA || ex_wr_src == WRREG_ALURESULT);
	assign ex_fwd_data = (ex_wr_src == WRREG_IMMDATA) ? ex_imm : alu_result;

	// execute is newest, then memory, writeback and the register file.
	function automatic word_t pick(reg_addr_t addr, word_t rf_data);
		word_t data;
		data = rf_data;
		if (wb_reg_write && addr == wb_rd)
			data = wb_wr_data;
		if (mem_reg_write && addr == mem_rd)
			data = mem_wr_data;
		if (ex_fwd_ok && addr == ex_rd)
			data = ex_fwd_data;
		return data;
	endfunction

	always_comb begin
		f_reg_ra_data = pick(reg_ra_addr, reg_ra_data);
		f_reg_rb_data = pick(reg_rb_addr, reg_rb_data);
		f_reg_rt_data = pick(reg_rt_addr, reg_rt_data);
	end

	// unused operands count in this conservative check.
	assign do_hazard = ex_dm_read &&
		(reg_ra_addr == ex_rd || reg_rb_addr == ex_rd || reg_rt_addr == ex_rd);

	// a stall only ever comes from a load that will write a register.
	always_comb begin
		assert #0 (!do_hazard || (ex_reg_write && ex_wr_src == WRREG_MEMDATA))
			else $error("hazard raised without a load in execute");
	end

endmodule

//--- reg_file.sv
module reg_file import cpu_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,

	input  reg_addr_t ra_addr,
	input  reg_addr_t rb_addr,
	input  reg_addr_t rt_addr,
	output word_t     ra_data,
	output word_t     rb_data,
	output word_t     rt_data,

	input  logic      we,
	input  reg_addr_t wr_addr,
	input  word_t     wr_data
);

	word_t regs [32];

	// register 0 is writable like any other.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// reads see the old value during a write, forward covers that.
	assign ra_data = regs[ra_addr];
	assign rb_data = regs[rb_addr];
	assign rt_data = regs[rt_addr];

endmodule

//--- result_stage.sv
module result_stage import cpu_pkg::*; #(
	parameter int DMEM_DEPTH = 64
) (
	input  logic      clk,
	input  logic      rst_n,

	input  logic      ex_valid,
	input  reg_addr_t ex_rd,
	input  wr_src_t   ex_wr_src,
	input  logic      ex_dm_read,
	input  logic      ex_dm_write,
	input  word_t     alu_result,
	input  word_t     ex_imm,
	input  word_t     ex_rt_data,

	output logic      mem_reg_write,
	output reg_addr_t mem_rd,
	output word_t     mem_wr_data,

	output logic      wb_reg_write,
	output reg_addr_t wb_rd,
	output word_t     wb_wr_data,

	output logic      wb_valid,
	output reg_addr_t wb_addr,
	output word_t     wb_data
);

	localparam int AW = $clog2(DMEM_DEPTH);

	word_t         dmem [DMEM_DEPTH];
	wr_src_t       mem_wr_src;
	logic          mem_dm_read;
	logic          mem_dm_write;
	word_t         mem_alu;
	word_t         mem_imm;
	word_t         mem_rt_data;
	logic [AW-1:0] mem_idx;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_wr_src   <= WRREG_NONE;
			mem_dm_read  <= 1'b0;
			mem_dm_write <= 1'b0;
		end else begin
			mem_wr_src   <= ex_valid ? ex_wr_src : WRREG_NONE;
			mem_dm_read  <= ex_valid && ex_dm_read;
			mem_dm_write <= ex_valid && ex_dm_write;
		end
	end

	always_ff @(posedge clk) begin
		mem_rd      <= ex_rd;
		mem_alu     <= alu_result;
		mem_imm     <= ex_imm;
		mem_rt_data <= ex_rt_data;
	end

	// word index wraps at the memory size.
	assign mem_idx = mem_alu[AW-1:0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DMEM_DEPTH; i++) begin
				dmem[i] <= '0;
			end
		end else if (mem_dm_write) begin
			dmem[mem_idx] <= mem_rt_data;
		end
	end

	assign mem_reg_write = (mem_wr_src != WRREG_NONE);

	always_comb begin
		if (mem_dm_read)
			mem_wr_data = dmem[mem_idx];
		else if (mem_wr_src == WRREG_IMMDATA)
			mem_wr_data = mem_imm;
		else
			mem_wr_data = mem_alu;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wb_reg_write <= 1'b0;
		else
			wb_reg_write <= mem_reg_write;
	end

	always_ff @(posedge clk) begin
		wb_rd      <= mem_rd;
		wb_wr_data <= mem_wr_data;
	end

	// each register write is reported once, no hold.
	assign wb_valid = wb_reg_write;
	assign wb_addr  = wb_rd;
	assign wb_data  = wb_wr_data;

	a_wb_valid_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		!$isunknown(wb_valid)
	) else $error("writeback valid is unknown");

endmodule

//--- tb_cpu_core.sv
module tb_cpu_core;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int DMEM_DEPTH = 64;
	localparam int N_RANDOM = 600;
	localparam int ACCEPT_LIMIT = 10;
	localparam int DRAIN_LIMIT = 20;
	localparam int PIPE_DEPTH = 4;

	localparam logic [3:0] OP_NOP  = 4'd0;
	localparam logic [3:0] OP_ADD  = 4'd1;
	localparam logic [3:0] OP_SUB  = 4'd2;
	localparam logic [3:0] OP_AND  = 4'd3;
	localparam logic [3:0] OP_OR   = 4'd4;
	localparam logic [3:0] OP_XOR  = 4'd5;
	localparam logic [3:0] OP_LI   = 4'd6;
	localparam logic [3:0] OP_ADDI = 4'd7;
	localparam logic [3:0] OP_LW   = 4'd8;
	localparam logic [3:0] OP_SW   = 4'd9;

	logic        clk;
	logic        rst_n;
	logic        instr_valid;
	logic [31:0] instr;
	logic        instr_ready;
	logic        wb_valid;
	logic [4:0]  wb_addr;
	logic [31:0] wb_data;

	integer      seed;
	logic [31:0] model_regs [32];
	logic [31:0] model_dmem [DMEM_DEPTH];
	logic [4:0]  exp_addr [$];
	logic [31:0] exp_data [$];
	int          mismatches;
	int          other_errors;
	int          writes_expected;
	int          writes_seen;
	int          stalls;
	logic        aborted;

	cpu_core #(
		.DMEM_DEPTH (DMEM_DEPTH)
	) u_cpu_core (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.instr_ready (instr_ready),
		.wb_valid    (wb_valid),
		.wb_addr     (wb_addr),
		.wb_data     (wb_data)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	function automatic logic [31:0] make_instr(logic [3:0] opc, logic [4:0] rt,
			logic [4:0] ra, logic [15:0] low);
		return {opc, 2'b00, rt, ra, low};
	endfunction

	// executes one instruction at a time in program order.
	task automatic model_exec(input logic [31:0] w);
		logic [3:0]  opc;
		logic [4:0]  rt;
		logic [4:0]  ra;
		logic [4:0]  rb;
		logic [31:0] imm;
		logic [31:0] addr;
		logic [31:0] res;
		logic        wr;
		opc  = w[31:28];
		rt   = w[25:21];
		ra   = w[20:16];
		rb   = w[15:11];
		imm  = {{16{w[15]}}, w[15:0]};
		addr = model_regs[ra] + imm;
		res  = '0;
		wr   = 1'b1;
		case (opc)
			OP_ADD:  res = model_regs[ra] + model_regs[rb];
			OP_SUB:  res = model_regs[ra] - model_regs[rb];
			OP_AND:  res = model_regs[ra] & model_regs[rb];
			OP_OR:   res = model_regs[ra] | model_regs[rb];
			OP_XOR:  res = model_regs[ra] ^ model_regs[rb];
			OP_LI:   res = imm;
			OP_ADDI: res = model_regs[ra] + imm;
			OP_LW:   res = model_dmem[addr % DMEM_DEPTH];
			OP_SW: begin
				model_dmem[addr % DMEM_DEPTH] = model_regs[rt];
				wr = 1'b0;
			end
			default: wr = 1'b0;
		endcase
		if (wr) begin
			model_regs[rt] = res;
			exp_addr.push_back(rt);
			exp_data.push_back(res);
			writes_expected++;
		end
	endtask

	// offer one instruction and hold it until the DUT takes it.
	task automatic issue(input logic [31:0] w);
		int   waited;
		logic accepted;
		waited = 0;
		accepted = 1'b0;
		if (!aborted) begin
			instr = w;
			instr_valid = 1'b1;
			while (!accepted && waited < ACCEPT_LIMIT) begin
				@(negedge clk);
				if (instr_ready) begin
					model_exec(w);
					accepted = 1'b1;
				end else begin
					stalls++;
				end
				@(posedge clk);
				#1;
				waited++;
			end
			instr_valid = 1'b0;
			if (!accepted) begin
				other_errors++;
				aborted = 1'b1;
				$display("timeout at %0t: instruction %h was not accepted", $time, w);
			end
		end
	endtask

	// registers come mostly from r0..r3 so that dependencies are frequent.
	function automatic logic [4:0] pick_reg();
		logic [31:0] r;
		r = $unsigned($random(seed));
		if (r % 5 == 0)
			return r[12:8];
		return r[9:8] & 2'b11;
	endfunction

	function automatic logic [31:0] random_instr();
		logic [31:0] r;
		logic [3:0]  opc;
		logic [15:0] low;
		r = $unsigned($random(seed));
		if (r % 20 < 10)
			opc = 4'(r % 20);
		else if (r % 20 < 13)
			opc = OP_LW;
		else if (r % 20 < 16)
			opc = OP_SW;
		else if (r % 20 < 18)
			opc = OP_LI;
		else
			opc = 4'(10 + (r[15:8] % 6));
		r = $random(seed);
		if (opc == OP_LI && r[31])
			low = 16'(r[3:0]);
		else if (opc == OP_LW || opc == OP_SW)
			low = {{9{r[6]}}, r[6:0]};
		else if (opc == OP_LI || opc == OP_ADDI)
			low = r[15:0];
		else
			low = {pick_reg(), r[10:0]};
		return make_instr(opc, pick_reg(), pick_reg(), low);
	endfunction

	// compare each register write with the oldest expected one.
	always @(negedge clk) begin
		if (rst_n && wb_valid === 1'b1) begin
			writes_seen++;
			if (exp_addr.size() == 0) begin
				other_errors++;
				$display("unexpected register write to r%0d at %0t", wb_addr, $time);
			end else begin
				assert (wb_addr == exp_addr[0] && wb_data == exp_data[0]) else begin
					mismatches++;
					$display("FAIL %0t: write r%0d = %h, expected r%0d = %h", $time,
						wb_addr, wb_data, exp_addr[0], exp_data[0]);
				end
				void'(exp_addr.pop_front());
				void'(exp_data.pop_front());
			end
		end
	end

	initial begin
		int waited;
		seed = 32'h830a_2190;
		rst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		mismatches = 0;
		other_errors = 0;
		writes_expected = 0;
		writes_seen = 0;
		stalls = 0;
		aborted = 1'b0;
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end
		for (int i = 0; i < DMEM_DEPTH; i++) begin
			model_dmem[i] = '0;
		end
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// untouched memory and registers read as zero.
		issue(make_instr(OP_LW, 5'd5, 5'd6, 16'd9));
		issue(make_instr(OP_ADD, 5'd7, 5'd8, {5'd9, 11'd0}));

		// store then load the same word through a wrapped address, then use it at once.
		issue(make_instr(OP_LI, 5'd2, 5'd0, 16'd5));
		issue(make_instr(OP_LI, 5'd1, 5'd0, 16'h9abc));
		issue(make_instr(OP_SW, 5'd1, 5'd2, 16'd3));
		issue(make_instr(OP_LW, 5'd3, 5'd2, 16'd67));
		issue(make_instr(OP_ADD, 5'd4, 5'd3, {5'd3, 11'd0}));

		for (int n = 0; n < N_RANDOM && !aborted; n++) begin
			if ($unsigned($random(seed)) % 5 == 0) begin
				@(posedge clk);
				#1;
			end
			issue(random_instr());
		end

		waited = 0;
		while (exp_addr.size() > 0 && waited < DRAIN_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		if (exp_addr.size() > 0) begin
			other_errors++;
			$display("timeout: %0d expected register writes never appeared", exp_addr.size());
		end

		// the last accepted instruction leaves writeback within this many edges.
		repeat (PIPE_DEPTH) @(posedge clk);

		assert (stalls > 0) else begin
			other_errors++;
			$display("instr_ready never dropped, no load-use stall was seen");
		end
		assert (writes_seen == writes_expected) else begin
			other_errors++;
			$display("saw %0d register writes, model made %0d", writes_seen, writes_expected);
		end

		$display("done: %0d mismatches, %0d other errors, %0d writes, %0d stall cycles",
			mismatches, other_errors, writes_seen, stalls);
		if (mismatches == 0 && other_errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule
